/* Bender.yml */
package:
  name: fetch_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_isa_pkg.sv
      - verilog/fetch_pkg.sv
      - verilog/wb_fetch_master.sv
      - verilog/instr_align_buffer.sv
      - verilog/compressed_expand.sv
      - verilog/fetch_output_stage.sv
      - verilog/fetch_unit_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/fetch_unit_tb.sv

/* bench/fetch_stimulus.txt */
// Word 0 image word count, word 1 record count, then image words from address 0
// Records follow, one per line: pc instruction compressed_flag
0000000C
00000014
00500093 002081B3 C60C4144 931E028E
15758426 6615459D 87118289 8C059BFD
8E558D2D 52B78F7D 00401234 403100B3
00000000 00500093 0
00000004 002081B3 0
00000008 00452483 1
0000000A 00B62423 1
0000000C 00329293 1
0000000E 00730333 1
00000010 00900433 1
00000012 FFD50513 1
00000014 00700593 1
00000016 00005637 1
00000018 0026D693 1
0000001A 40475713 1
0000001C FFF7F793 1
0000001E 40940433 1
00000020 00B54533 1
00000022 00D66633 1
00000024 00F77733 1
00000026 123452B7 0
0000002A 00000040 1
0000002C 403100B3 0

/* bench/fetch_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_unit_tb;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int STIM_WORDS     = 128;

    logic                       clk;
    logic                       arst_n;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [3:0]                 wb_sel;
    logic [`FETCH_WB_ADR_W-1:0] wb_adr;
    rv_isa_pkg::instr_t         wb_dat_r = '0;
    logic                       wb_ack = 1'b0;
    logic                       out_valid;
    logic                       out_ready = 1'b0;
    rv_isa_pkg::instr_t         out_instr;
    logic                       out_compressed;
    fetch_pkg::pc_t             out_pc;

    logic [31:0] stim [0:STIM_WORDS-1];                 // Counts, image, then records
    int          n_img;
    int          n_rec;
    int          seed = 17513;
    logic        busy = 1'b0;
    logic [1:0]  ack_delay = 2'd0;
    int          test_errors = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    fetch_unit_top uut (
        .clk            (clk),
        .arst_n         (arst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_sel         (wb_sel),
        .wb_adr         (wb_adr),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_instr      (out_instr),
        .out_compressed (out_compressed),
        .out_pc         (out_pc)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic rv_isa_pkg::instr_t mem_word(input logic [`FETCH_WB_ADR_W-1:0] adr);
        if (adr < n_img)
            return stim[2 + adr];
        return {adr, 2'b11};                            // Past the image, full-length filler
    endfunction

    function automatic string kind_name(input rv_isa_pkg::instr_t instr, input logic flag);
        string base;
        case (instr[6:0])
            rv_isa_pkg::LOAD:   base = "load";
            rv_isa_pkg::STORE:  base = "store";
            rv_isa_pkg::OP_IMM: base = "op_imm";
            rv_isa_pkg::OP:     base = "op";
            rv_isa_pkg::LUI:    base = "lui";
            default:            base = "other";
        endcase
        return flag ? {"c_", base} : base;
    endfunction

    task automatic check_instr(input string name, input rv_isa_pkg::instr_t exp,
                               input rv_isa_pkg::instr_t act);
        if (exp !== act)
        begin
            $display("MISMATCH %s instr: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_pc(input string name, input fetch_pkg::pc_t exp,
                            input fetch_pkg::pc_t act);
        if (exp !== act)
        begin
            $display("MISMATCH %s pc: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("MISMATCH %s flag: expected %b, actual %b", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_sel(input string name, input logic [3:0] exp,
                             input logic [3:0] act);
        if (exp !== act)
        begin
            $display("MISMATCH %s sel: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0)
        begin
            pass_count++;
            $display("PASS %s", name);
        end
        else
        begin
            fail_count++;
            $display("FAIL %s", name);
        end
        test_errors = 0;
    endtask

    // Wishbone slave with random ack delay, plus random decoder back-pressure
    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_ack    <= 1'b0;
            busy      <= 1'b0;
            out_ready <= 1'b0;
        end
        else
        begin
            out_ready <= (2'($random(seed)) != 2'd0);   // Ready about 3 cycles in 4
            if (wb_ack)
            begin
                wb_ack <= 1'b0;
                busy   <= 1'b0;
            end
            else if (wb_cyc && wb_stb)
            begin
                if (!busy)
                begin
                    busy      <= 1'b1;
                    ack_delay <= 2'($random(seed));
                end
                else if (ack_delay != 2'd0)
                    ack_delay <= ack_delay - 2'd1;
                else
                begin
                    wb_ack   <= 1'b1;
                    wb_dat_r <= mem_word(wb_adr);
                end
            end
        end
    end

    initial
    begin
        int                 r;
        int                 base;
        int                 wait_cnt;
        bit                 timed_out;
        string              name;
        fetch_pkg::pc_t     exp_pc;
        rv_isa_pkg::instr_t exp_instr;
        logic               exp_flag;

        timed_out = 1'b0;
        arst_n    = 1'b0;
        $readmemh("bench/fetch_stimulus.txt", stim);
        n_img = stim[0];
        n_rec = stim[1];

        @(posedge clk);
        @(negedge clk);
        check_flag("reset_idle_out_valid", 1'b0, out_valid);
        check_flag("reset_idle_wb_cyc", 1'b0, wb_cyc);
        check_flag("reset_idle_wb_stb", 1'b0, wb_stb);
        end_test("reset_idle");
        @(posedge clk);
        arst_n <= 1'b1;

        wait_cnt = 0;
        while (!wb_cyc && wait_cnt < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!wb_cyc)
        begin
            $display("Timeout: no Wishbone request after reset");
            test_errors++;
            timed_out = 1'b1;
        end
        else
        begin
            check_pc("first_request", `FETCH_RESET_PC, {wb_adr, 2'b00});
            check_flag("first_request_stb", 1'b1, wb_stb);
            check_flag("first_request_we", 1'b0, wb_we);
            check_sel("first_request_sel", 4'hf, wb_sel);
        end
        end_test("first_request");

        if (n_rec == 0)
        begin
            $display("Stimulus file holds no expected records");
            fail_count++;
        end

        for (r = 0; r < n_rec && !timed_out; r++)
        begin
            base      = 2 + n_img + 3 * r;
            exp_pc    = stim[base];
            exp_instr = stim[base + 1];
            exp_flag  = stim[base + 2][0];
            name      = $sformatf("%s_at_%h", kind_name(exp_instr, exp_flag), exp_pc);
            wait_cnt  = 0;
            @(negedge clk);
            while (!(out_valid && out_ready) && wait_cnt < TIMEOUT_CYCLES)
            begin
                @(negedge clk);
                wait_cnt++;
            end
            if (!(out_valid && out_ready))
            begin
                $display("Timeout: no instruction accepted by the decoder for %s", name);
                test_errors++;
                timed_out = 1'b1;
            end
            else
            begin
                check_pc(name, exp_pc, out_pc);
                check_instr(name, exp_instr, out_instr);
                check_flag(name, exp_flag, out_compressed);
            end
            end_test(name);
        end

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/fetch_pkg.sv
verilog/wb_fetch_master.sv
verilog/instr_align_buffer.sv
verilog/compressed_expand.sv
verilog/fetch_output_stage.sv
verilog/fetch_unit_top.sv
bench/fetch_unit_tb.sv

/* verilog/compressed_expand.sv */
`timescale 1ns/1ps
`default_nettype none

module compressed_expand (
    input  rv_isa_pkg::instr_t  raw_instr,
    output logic                is_compressed,
    output rv_isa_pkg::instr_t  expanded_instr
);

    logic [15:0]           hw;
    logic [2:0]            funct3;
    logic [4:0]            rd_c;                        // Compact rd'/rs1', x8 to x15
    logic [4:0]            rs2_c;
    logic [11:0]           imm6;                        // Sign extended 6-bit immediate
    rv_isa_pkg::quadrant_e quad;

    assign hw     = raw_instr[15:0];
    assign funct3 = hw[15:13];
    assign rd_c   = {2'b01, hw[9:7]};
    assign rs2_c  = {2'b01, hw[4:2]};
    assign imm6   = {{6{hw[12]}}, hw[12], hw[6:2]};
    assign quad   = rv_isa_pkg::quadrant_e'(hw[1:0]);

    always_comb
    begin
        is_compressed  = (quad != rv_isa_pkg::Q_FULL);
        expanded_instr = {16'h0000, hw};                // Unsupported RVC, low half kept
        case (quad)
            rv_isa_pkg::Q_FULL:
                expanded_instr = raw_instr;
            rv_isa_pkg::Q0:
            begin
                if (funct3 == 3'b010)                   // C.LW
                    expanded_instr = {5'b0, hw[5], hw[12:10], hw[6], 2'b00, rd_c, 3'b010,
                                      rs2_c, rv_isa_pkg::LOAD};
                else if (funct3 == 3'b110)              // C.SW
                    expanded_instr = {5'b0, hw[5], hw[12], rs2_c, rd_c, 3'b010,
                                      hw[11:10], hw[6], 2'b00, rv_isa_pkg::STORE};
            end
            rv_isa_pkg::Q1:
            begin
                if (funct3 == 3'b000)                   // C.ADDI
                    expanded_instr = {imm6, hw[11:7], 3'b000, hw[11:7], rv_isa_pkg::OP_IMM};
                else if (funct3 == 3'b010)              // C.LI
                    expanded_instr = {imm6, 5'b0, 3'b000, hw[11:7], rv_isa_pkg::OP_IMM};
                else if (funct3 == 3'b011 && hw[11:7] != 5'd2)  // C.LUI, x2 is ADDI16SP
                    expanded_instr = {{14{hw[12]}}, hw[12], hw[6:2], hw[11:7], rv_isa_pkg::LUI};
                else if (funct3 == 3'b100)
                begin
                    case (hw[11:10])
                        2'b00:                          // C.SRLI
                            expanded_instr = {7'b0000000, hw[6:2], rd_c, 3'b101, rd_c,
                                              rv_isa_pkg::OP_IMM};
                        2'b01:                          // C.SRAI
                            expanded_instr = {7'b0100000, hw[6:2], rd_c, 3'b101, rd_c,
                                              rv_isa_pkg::OP_IMM};
                        2'b10:                          // C.ANDI
                            expanded_instr = {imm6, rd_c, 3'b111, rd_c, rv_isa_pkg::OP_IMM};
                        default:
                        begin
                            // Register ops, hw[12] set is RV64 only
                            if (!hw[12])
                            begin
                                case (hw[6:5])
                                    2'b00: expanded_instr = {7'b0100000, rs2_c, rd_c, 3'b000,
                                                             rd_c, rv_isa_pkg::OP};
                                    2'b01: expanded_instr = {7'b0, rs2_c, rd_c, 3'b100,
                                                             rd_c, rv_isa_pkg::OP};
                                    2'b10: expanded_instr = {7'b0, rs2_c, rd_c, 3'b110,
                                                             rd_c, rv_isa_pkg::OP};
                                    default: expanded_instr = {7'b0, rs2_c, rd_c, 3'b111,
                                                               rd_c, rv_isa_pkg::OP};
                                endcase
                            end
                        end
                    endcase
                end
            end
            default:
            begin
                if (funct3 == 3'b000)                   // C.SLLI
                    expanded_instr = {7'b0, hw[6:2], hw[11:7], 3'b001, hw[11:7],
                                      rv_isa_pkg::OP_IMM};
                else if (funct3 == 3'b100 && hw[6:2] != 5'd0)   // rs2 zero is JR/JALR
                begin
                    if (hw[12])                         // C.ADD
                        expanded_instr = {7'b0, hw[6:2], hw[11:7], 3'b000, hw[11:7],
                                          rv_isa_pkg::OP};
                    else                                // C.MV
                        expanded_instr = {7'b0, hw[6:2], 5'b0, 3'b000, hw[11:7],
                                          rv_isa_pkg::OP};
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// First fetch address after reset, word aligned
`define FETCH_RESET_PC 32'h0000_0000

// Data and byte address width
`define FETCH_XLEN 32

// Wishbone word address width
`define FETCH_WB_ADR_W 30

`endif

/* verilog/fetch_output_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_output_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               instr_valid,
    output logic               instr_ready,
    input  rv_isa_pkg::instr_t instr_in,
    input  logic               compressed_in,
    input  fetch_pkg::pc_t     pc_in,
    output logic               out_valid,
    input  logic               out_ready,
    output rv_isa_pkg::instr_t out_instr,
    output logic               out_compressed,
    output fetch_pkg::pc_t     out_pc
);

    // Empty, or current entry leaves this cycle
    assign instr_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (instr_ready)
            out_valid <= instr_valid;
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid && instr_ready)
        begin
            out_instr      <= instr_in;
            out_compressed <= compressed_in;
            out_pc         <= pc_in;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_pkg.sv */
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

    // Byte address of a fetched word or instruction
    typedef logic [`FETCH_XLEN-1:0] pc_t;

    // Wishbone classic master, idle or waiting for ack
    typedef enum logic
    {
        BUS_IDLE = 1'b0,
        BUS_WAIT = 1'b1
    } bus_state_e;

endpackage

`default_nettype wire

/* verilog/fetch_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_unit_top (
    input  logic                        clk,
    input  logic                        arst_n,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_we,
    output logic [3:0]                  wb_sel,
    output logic [`FETCH_WB_ADR_W-1:0]  wb_adr,
    input  rv_isa_pkg::instr_t          wb_dat_r,
    input  logic                        wb_ack,
    output logic                        out_valid,
    input  logic                        out_ready,
    output rv_isa_pkg::instr_t          out_instr,
    output logic                        out_compressed,
    output fetch_pkg::pc_t              out_pc
);

    logic               word_valid;
    logic               word_ready;
    rv_isa_pkg::instr_t word_data;
    fetch_pkg::pc_t     word_pc;
    rv_isa_pkg::instr_t raw_instr;
    rv_isa_pkg::instr_t expanded_instr;
    logic               is_compressed;
    logic               instr_valid;
    logic               instr_ready;
    fetch_pkg::pc_t     instr_pc;

    wb_fetch_master u_master (
        .clk        (clk),
        .arst_n     (arst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_sel     (wb_sel),
        .wb_adr     (wb_adr),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .word_data  (word_data),
        .word_pc    (word_pc)
    );

    instr_align_buffer u_align (
        .clk         (clk),
        .arst_n      (arst_n),
        .word_valid  (word_valid),
        .word_ready  (word_ready),
        .word_data   (word_data),
        .word_pc     (word_pc),
        .raw_instr   (raw_instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr_pc    (instr_pc)
    );

    compressed_expand u_expand (
        .raw_instr      (raw_instr),
        .is_compressed  (is_compressed),
        .expanded_instr (expanded_instr)
    );

    fetch_output_stage u_out (
        .clk            (clk),
        .arst_n         (arst_n),
        .instr_valid    (instr_valid),
        .instr_ready    (instr_ready),
        .instr_in       (expanded_instr),
        .compressed_in  (is_compressed),
        .pc_in          (instr_pc),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_instr      (out_instr),
        .out_compressed (out_compressed),
        .out_pc         (out_pc)
    );

endmodule

`default_nettype wire

/* verilog/instr_align_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module instr_align_buffer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               word_valid,
    output logic               word_ready,
    input  rv_isa_pkg::instr_t word_data,
    input  fetch_pkg::pc_t     word_pc,
    output rv_isa_pkg::instr_t raw_instr,
    output logic               instr_valid,
    input  logic               instr_ready,
    output fetch_pkg::pc_t     instr_pc
);

    logic [2:0][15:0] hw_q;                             // Slot 0 is the oldest
    logic [2:0][15:0] hw_q_nxt;
    logic [1:0]       count;
    logic [1:0]       cnt_after;
    logic [1:0]       n_used;
    fetch_pkg::pc_t   head_pc;
    fetch_pkg::pc_t   pc_step;
    logic             is_full;
    logic             consume;
    logic             word_take;

    assign is_full     = (rv_isa_pkg::quadrant_e'(hw_q[0][1:0]) == rv_isa_pkg::Q_FULL);
    assign instr_valid = is_full ? (count >= 2'd2) : (count != 2'd0);
    assign raw_instr   = {hw_q[1], hw_q[0]};           // Upper half unused when compressed
    assign instr_pc    = head_pc;

    assign consume   = instr_valid && instr_ready;
    assign n_used    = consume ? (is_full ? 2'd2 : 2'd1) : 2'd0;
    assign cnt_after = count - n_used;
    assign pc_step   = is_full ? 32'd4 : 32'd2;

    // Room for a whole word after this cycle's consumption
    assign word_ready = (cnt_after <= 2'd1);
    assign word_take  = word_valid && word_ready;

    always_comb
    begin
        hw_q_nxt = hw_q;
        case (n_used)
            2'd1:
            begin
                hw_q_nxt[0] = hw_q[1];
                hw_q_nxt[1] = hw_q[2];
            end
            2'd2:
                hw_q_nxt[0] = hw_q[2];
            default: ;
        endcase
        if (word_take)
        begin
            case (cnt_after)
                2'd0:
                begin
                    hw_q_nxt[0] = word_data[15:0];
                    hw_q_nxt[1] = word_data[31:16];
                end
                2'd1:
                begin
                    hw_q_nxt[1] = word_data[15:0];
                    hw_q_nxt[2] = word_data[31:16];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        hw_q <= hw_q_nxt;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            count   <= 2'd0;
            head_pc <= `FETCH_RESET_PC;
        end
        else
        begin
            count <= cnt_after + (word_take ? 2'd2 : 2'd0);
            if (word_take && cnt_after == 2'd0)
                head_pc <= word_pc;                     // Queue drains, restart at new word
            else if (consume)
                head_pc <= head_pc + pc_step;
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_isa_pkg.sv */
`default_nettype none

`include "fetch_config.svh"

package rv_isa_pkg;

    // One instruction word, full length or expanded
    typedef logic [`FETCH_XLEN-1:0] instr_t;

    // Major opcodes produced by the RVC expander
    typedef enum logic [6:0]
    {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111
    } opcode_e;

    // Low two bits of an encoding, Q_FULL marks a 32-bit instruction
    typedef enum logic [1:0]
    {
        Q0     = 2'b00,
        Q1     = 2'b01,
        Q2     = 2'b10,
        Q_FULL = 2'b11
    } quadrant_e;

endpackage

`default_nettype wire

/* verilog/wb_fetch_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module wb_fetch_master (
    input  logic                        clk,
    input  logic                        arst_n,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_we,
    output logic [3:0]                  wb_sel,
    output logic [`FETCH_WB_ADR_W-1:0]  wb_adr,
    input  rv_isa_pkg::instr_t          wb_dat_r,
    input  logic                        wb_ack,
    output logic                        word_valid,
    input  logic                        word_ready,
    output rv_isa_pkg::instr_t          word_data,
    output fetch_pkg::pc_t              word_pc
);

    fetch_pkg::bus_state_e state;

    assign wb_cyc = (state == fetch_pkg::BUS_WAIT);
    assign wb_stb = (state == fetch_pkg::BUS_WAIT);
    assign wb_we  = 1'b0;                               // Read only
    assign wb_sel = 4'hf;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= fetch_pkg::BUS_IDLE;
            wb_adr     <= `FETCH_WB_ADR_W'(`FETCH_RESET_PC >> 2);
            word_valid <= 1'b0;
        end
        else
        begin
            case (state)
                fetch_pkg::BUS_IDLE:
                begin
                    if (word_valid && word_ready)
                        word_valid <= 1'b0;
                    // Slot is free or frees this cycle
                    if (!word_valid || word_ready)
                        state <= fetch_pkg::BUS_WAIT;
                end
                fetch_pkg::BUS_WAIT:
                begin
                    if (wb_ack)
                    begin
                        state      <= fetch_pkg::BUS_IDLE;  // Cycle ends, stb drops
                        wb_adr     <= wb_adr + 1'b1;
                        word_valid <= 1'b1;
                    end
                end
                default:
                    state <= fetch_pkg::BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wb_cyc && wb_ack)
        begin
            word_data <= wb_dat_r;
            word_pc   <= {wb_adr, 2'b00};                   // Byte address of the word
        end
    end

endmodule

`default_nettype wire
